/* logic/rv_pkg.sv */
// rv32i subset core definitions
`default_nettype none

package rv_pkg;

	// datapath widths
	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] data_t;
	typedef logic [4:0] reg_addr_t;

	// instruction memory, one word per entry
	localparam int IMEM_DEPTH = 64;
	localparam int IMEM_AW = 6;

	// data memory is indexed by byte address bits 9 to 2
	localparam int DMEM_DEPTH = 256;
	localparam int DMEM_AW = 8;

	// major opcodes, instruction bits 6:0
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		SYSTEM = 7'b1110011
	} opcode_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR
	} alu_op_t;

	// where an execute operand comes from
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

	localparam logic [31:0] EBREAK_INSTR = 32'h0010_0073;

	// addi x0, x0, 0
	localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire

/* logic/fetch.sv */
// instruction fetch stage
`timescale 1ns/1ps
`default_nettype none

module fetch (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       imem_we,
	input  logic [rv_pkg::IMEM_AW-1:0] imem_addr,
	input  logic [31:0]                imem_wdata,
	input  logic                       hold,
	input  logic                       flush,
	input  logic                       resume_flush,
	input  logic                       branch_taken,
	input  rv_pkg::data_t              branch_target,
	output rv_pkg::data_t              if_pc,
	output logic [31:0]                if_instr
);
	import rv_pkg::*;

	logic [31:0] imem [IMEM_DEPTH];
	data_t pc;
	logic [31:0] fetched;

	// program load port
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_wdata;
		end
	end

	assign fetched = imem[pc[IMEM_AW+1:2]];

	// branch redirect wins over any hold
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (branch_taken) begin
			pc <= branch_target;
		end else if (!hold) begin
			pc <= pc + data_t'(4);
		end
	end

	// if/id register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_instr <= NOP_INSTR;
		end else if (flush || resume_flush) begin
			if_instr <= NOP_INSTR;
		end else if (!hold) begin
			if_instr <= fetched;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			if_pc <= pc;
		end
	end

endmodule

`default_nettype wire

/* logic/decode.sv */
// instruction decode stage
`timescale 1ns/1ps
`default_nettype none

module decode (
	input  logic              clk,
	input  logic              rst_n,
	input  rv_pkg::data_t     if_pc,
	input  logic [31:0]       if_instr,
	input  logic              hold,
	input  logic              flush,
	input  logic              wb_we,
	input  rv_pkg::reg_addr_t wb_rd,
	input  rv_pkg::data_t     wb_data,
	output rv_pkg::data_t     id_pc,
	output rv_pkg::data_t     id_rs1_val,
	output rv_pkg::data_t     id_rs2_val,
	output rv_pkg::data_t     id_imm,
	output rv_pkg::reg_addr_t id_rs1,
	output rv_pkg::reg_addr_t id_rs2,
	output rv_pkg::reg_addr_t id_rd,
	output rv_pkg::alu_op_t   id_alu_op,
	output logic              id_use_imm,
	output logic              id_reg_we,
	output logic              id_is_load,
	output logic              id_is_store,
	output logic              id_is_branch,
	output logic              id_branch_ne
);
	import rv_pkg::*;

	data_t regs [32];

	logic [31:0] instr;
	opcode_t opcode;
	logic [2:0] funct3;
	reg_addr_t rs1, rs2, rd;
	data_t rs1_val, rs2_val;
	data_t imm_i, imm_s, imm_b;

	data_t imm;
	alu_op_t alu_op;
	logic use_imm, reg_we, is_load, is_store, is_branch, branch_ne;

	// a stalled or flushed slot decodes as the nop
	assign instr = (hold || flush) ? NOP_INSTR : if_instr;
	assign opcode = opcode_t'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

	// register file, x0 is never written
	always_ff @(posedge clk) begin
		if (wb_we && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// write-through so a same-cycle writeback is seen here
	assign rs1_val = (rs1 == '0) ? '0 : (wb_we && wb_rd == rs1) ? wb_data : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 : (wb_we && wb_rd == rs2) ? wb_data : regs[rs2];

	always_comb begin
		imm = '0;
		alu_op = ALU_ADD;
		use_imm = 1'b0;
		reg_we = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		is_branch = 1'b0;
		branch_ne = 1'b0;
		case (opcode)
			OP: begin
				reg_we = 1'b1;
				case (funct3)
					3'b000: alu_op = instr[30] ? ALU_SUB : ALU_ADD;
					3'b100: alu_op = ALU_XOR;
					3'b110: alu_op = ALU_OR;
					3'b111: alu_op = ALU_AND;
					default: reg_we = 1'b0;
				endcase
			end
			OP_IMM: begin
				imm = imm_i;
				use_imm = 1'b1;
				reg_we = (funct3 == 3'b000);
			end
			LOAD: begin
				imm = imm_i;
				use_imm = 1'b1;
				is_load = (funct3 == 3'b010);
				reg_we = is_load;
			end
			STORE: begin
				imm = imm_s;
				use_imm = 1'b1;
				is_store = (funct3 == 3'b010);
			end
			BRANCH: begin
				imm = imm_b;
				is_branch = (funct3[2:1] == 2'b00);
				branch_ne = funct3[0];
			end
			// ebreak and unsupported opcodes stay a bubble
			default: use_imm = 1'b0;
		endcase
		if (rd == '0) begin
			reg_we = 1'b0;
		end
	end

	// id/ex register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_rs1 <= '0;
			id_rs2 <= '0;
			id_rd <= '0;
			id_alu_op <= ALU_ADD;
			id_use_imm <= 1'b0;
			id_reg_we <= 1'b0;
			id_is_load <= 1'b0;
			id_is_store <= 1'b0;
			id_is_branch <= 1'b0;
			id_branch_ne <= 1'b0;
		end else begin
			id_rs1 <= rs1;
			id_rs2 <= rs2;
			id_rd <= reg_we ? rd : '0;
			id_alu_op <= alu_op;
			id_use_imm <= use_imm;
			id_reg_we <= reg_we;
			id_is_load <= is_load;
			id_is_store <= is_store;
			id_is_branch <= is_branch;
			id_branch_ne <= branch_ne;
		end
	end

	always_ff @(posedge clk) begin
		id_pc <= if_pc;
		id_rs1_val <= rs1_val;
		id_rs2_val <= rs2_val;
		id_imm <= imm;
	end

endmodule

`default_nettype wire

/* logic/execute.sv */
// execute stage
`timescale 1ns/1ps
`default_nettype none

module execute (
	input  logic              clk,
	input  logic              rst_n,
	input  rv_pkg::data_t     id_pc,
	input  rv_pkg::data_t     id_rs1_val,
	input  rv_pkg::data_t     id_rs2_val,
	input  rv_pkg::data_t     id_imm,
	input  rv_pkg::reg_addr_t id_rd,
	input  rv_pkg::alu_op_t   id_alu_op,
	input  logic              id_use_imm,
	input  logic              id_reg_we,
	input  logic              id_is_load,
	input  logic              id_is_store,
	input  logic              id_is_branch,
	input  logic              id_branch_ne,
	input  rv_pkg::fwd_sel_t  fwd_a,
	input  rv_pkg::fwd_sel_t  fwd_b,
	input  rv_pkg::data_t     mem_fwd_data,
	input  rv_pkg::data_t     wb_fwd_data,
	output logic              branch_taken,
	output rv_pkg::data_t     branch_target,
	output rv_pkg::data_t     ex_alu,
	output rv_pkg::data_t     ex_store_data,
	output rv_pkg::reg_addr_t ex_rd,
	output logic              ex_reg_we,
	output logic              ex_is_load,
	output logic              ex_is_store
);
	import rv_pkg::*;

	data_t op_a, op_b, alu_b, alu_res;

	function automatic data_t fwd_mux(
		input fwd_sel_t sel,
		input data_t reg_val,
		input data_t mem_val,
		input data_t wb_val
	);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign op_a = fwd_mux(fwd_a, id_rs1_val, mem_fwd_data, wb_fwd_data);
	assign op_b = fwd_mux(fwd_b, id_rs2_val, mem_fwd_data, wb_fwd_data);
	assign alu_b = id_use_imm ? id_imm : op_b;

	// also forms load and store addresses
	always_comb begin
		case (id_alu_op)
			ALU_SUB: alu_res = op_a - alu_b;
			ALU_AND: alu_res = op_a & alu_b;
			ALU_OR:  alu_res = op_a | alu_b;
			ALU_XOR: alu_res = op_a ^ alu_b;
			default: alu_res = op_a + alu_b;
		endcase
	end

	// beq or bne resolved here
	assign branch_taken = id_is_branch && ((op_a == op_b) != id_branch_ne);
	assign branch_target = id_pc + id_imm;

	// ex/mem register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_rd <= '0;
			ex_reg_we <= 1'b0;
			ex_is_load <= 1'b0;
			ex_is_store <= 1'b0;
		end else begin
			ex_rd <= id_rd;
			ex_reg_we <= id_reg_we;
			ex_is_load <= id_is_load;
			ex_is_store <= id_is_store;
		end
	end

	// store data takes the forwarded rs2
	always_ff @(posedge clk) begin
		ex_alu <= alu_res;
		ex_store_data <= op_b;
	end

endmodule

`default_nettype wire

/* logic/memory.sv */
// memory and writeback stage
`timescale 1ns/1ps
`default_nettype none

module memory (
	input  logic              clk,
	input  logic              rst_n,
	input  rv_pkg::data_t     ex_alu,
	input  rv_pkg::data_t     ex_store_data,
	input  rv_pkg::reg_addr_t ex_rd,
	input  logic              ex_reg_we,
	input  logic              ex_is_load,
	input  logic              ex_is_store,
	output logic              wb_we,
	output rv_pkg::reg_addr_t wb_rd,
	output rv_pkg::data_t     wb_data,
	output logic              retire_valid,
	output rv_pkg::reg_addr_t retire_rd,
	output rv_pkg::data_t     retire_data
);
	import rv_pkg::*;

	data_t dmem [DMEM_DEPTH];
	logic [DMEM_AW-1:0] dmem_idx;
	data_t load_data;

	// word index from the byte address
	assign dmem_idx = ex_alu[DMEM_AW+1:2];
	assign load_data = dmem[dmem_idx];

	always_ff @(posedge clk) begin
		if (ex_is_store) begin
			dmem[dmem_idx] <= ex_store_data;
		end
	end

	// mem/wb register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_we <= 1'b0;
			wb_rd <= '0;
		end else begin
			wb_we <= ex_reg_we;
			wb_rd <= ex_rd;
		end
	end

	always_ff @(posedge clk) begin
		wb_data <= ex_is_load ? load_data : ex_alu;
	end

	assign retire_valid = wb_we && (wb_rd != '0);
	assign retire_rd = wb_rd;
	assign retire_data = wb_data;

endmodule

`default_nettype wire

/* logic/hazard_ctrl.sv */
// forwarding and hazard control
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl (
	input  rv_pkg::reg_addr_t id_rs1,
	input  rv_pkg::reg_addr_t id_rs2,
	input  rv_pkg::reg_addr_t id_rd,
	input  logic              id_reg_we,
	input  logic              id_is_load,
	input  logic [31:0]       if_instr,
	input  rv_pkg::reg_addr_t ex_rd,
	input  logic              ex_reg_we,
	input  rv_pkg::reg_addr_t wb_rd,
	input  logic              wb_we,
	input  logic              branch_taken,
	output rv_pkg::fwd_sel_t  fwd_a,
	output rv_pkg::fwd_sel_t  fwd_b,
	output logic              stall_front,
	output logic              flush_front
);
	import rv_pkg::*;

	opcode_t dec_op;
	reg_addr_t dec_rs1, dec_rs2;
	logic uses_rs1, uses_rs2;
	logic rs1_hit, rs2_hit;

	// nearer producer in ex/mem wins over mem/wb
	function automatic fwd_sel_t fwd_pick(
		input reg_addr_t rs,
		input logic m_we,
		input reg_addr_t m_rd,
		input logic w_we,
		input reg_addr_t w_rd
	);
		if (rs == '0) begin
			return FWD_REG;
		end else if (m_we && m_rd == rs) begin
			return FWD_MEM;
		end else if (w_we && w_rd == rs) begin
			return FWD_WB;
		end
		return FWD_REG;
	endfunction

	assign fwd_a = fwd_pick(id_rs1, ex_reg_we, ex_rd, wb_we, wb_rd);
	assign fwd_b = fwd_pick(id_rs2, ex_reg_we, ex_rd, wb_we, wb_rd);

	// which source registers the instruction in decode reads
	assign dec_op = opcode_t'(if_instr[6:0]);
	assign dec_rs1 = if_instr[19:15];
	assign dec_rs2 = if_instr[24:20];

	always_comb begin
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		case (dec_op)
			OP, STORE, BRANCH: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			OP_IMM, LOAD: uses_rs1 = 1'b1;
			default: uses_rs2 = 1'b0;
		endcase
	end

	// load in execute feeding the instruction in decode
	assign rs1_hit = uses_rs1 && (dec_rs1 == id_rd);
	assign rs2_hit = uses_rs2 && (dec_rs2 == id_rd);
	assign stall_front = id_is_load && id_reg_we && (rs1_hit || rs2_hit);

	assign flush_front = branch_taken;

endmodule

`default_nettype wire

/* logic/debug_halt.sv */
// ebreak halt control
`timescale 1ns/1ps
`default_nettype none

module debug_halt (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] if_instr,
	input  logic        stall_front,
	input  logic        debug_resume,
	output logic        halt_stall,
	output logic        resume_flush,
	output logic        halted
);
	import rv_pkg::*;

	typedef enum logic [2:0] {
		HALT_IDLE,
		HALT_DRAIN_1,
		HALT_DRAIN_2,
		HALT_DRAIN_3,
		HALT_WAIT
	} halt_state_t;

	halt_state_t state, state_nxt;
	logic ebreak_seen;

	// the resume cycle still shows the old ebreak in if/id
	assign ebreak_seen = (if_instr == EBREAK_INSTR) && !stall_front && !resume_flush;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= HALT_IDLE;
			resume_flush <= 1'b0;
		end else begin
			state <= state_nxt;
			resume_flush <= (state == HALT_WAIT) && debug_resume;
		end
	end

	// three cycles to drain the older instructions
	always_comb begin
		case (state)
			HALT_IDLE:    state_nxt = ebreak_seen ? HALT_DRAIN_1 : HALT_IDLE;
			HALT_DRAIN_1: state_nxt = HALT_DRAIN_2;
			HALT_DRAIN_2: state_nxt = HALT_DRAIN_3;
			HALT_DRAIN_3: state_nxt = HALT_WAIT;
			HALT_WAIT:    state_nxt = debug_resume ? HALT_IDLE : HALT_WAIT;
			default:      state_nxt = HALT_IDLE;
		endcase
	end

	// pc also holds in the resume cycle so ebreak+4 is fetched next
	assign halt_stall = (state != HALT_IDLE) || ebreak_seen || resume_flush;
	assign halted = (state == HALT_WAIT);

endmodule

`default_nettype wire

/* logic/proc.sv */
// five-stage rv32i subset core
`timescale 1ns/1ps
`default_nettype none

module proc (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       imem_we,
	input  logic [rv_pkg::IMEM_AW-1:0] imem_addr,
	input  logic [31:0]                imem_wdata,
	input  logic                       debug_resume,
	output logic                       halted,
	output logic                       retire_valid,
	output rv_pkg::reg_addr_t          retire_rd,
	output rv_pkg::data_t              retire_data
);
	import rv_pkg::*;

	// if/id
	data_t if_pc;
	logic [31:0] if_instr;

	// id/ex
	data_t id_pc, id_rs1_val, id_rs2_val, id_imm;
	reg_addr_t id_rs1, id_rs2, id_rd;
	alu_op_t id_alu_op;
	logic id_use_imm, id_reg_we, id_is_load, id_is_store;
	logic id_is_branch, id_branch_ne;

	// ex/mem
	data_t ex_alu, ex_store_data;
	reg_addr_t ex_rd;
	logic ex_reg_we, ex_is_load, ex_is_store;

	// mem/wb
	data_t wb_data;
	reg_addr_t wb_rd;
	logic wb_we;

	// branch, forwarding and stall control
	logic branch_taken;
	data_t branch_target;
	fwd_sel_t fwd_a, fwd_b;
	logic stall_front, flush_front;
	logic halt_stall, resume_flush;
	logic hold;
	logic halt_block;

	assign hold = stall_front | halt_stall;

	// an ebreak behind a load-use stall or a taken branch is not taken yet
	assign halt_block = stall_front | flush_front;

	fetch fetch0 (
		.flush (flush_front),
		.*
	);

	decode decode0 (
		.flush (flush_front),
		.*
	);

	execute execute0 (
		.mem_fwd_data (ex_alu),
		.wb_fwd_data  (wb_data),
		.*
	);

	memory memory0 (
		.*
	);

	hazard_ctrl hazard0 (
		.*
	);

	debug_halt halt0 (
		.stall_front (halt_block),
		.*
	);

endmodule

`default_nettype wire

/* dv/rv_model.sv */
// instruction set model and encoders
`default_nettype none

package rv_model;
	import rv_pkg::*;

	function automatic logic [31:0] enc_op(input alu_op_t op, input reg_addr_t rd,
		input reg_addr_t rs1, input reg_addr_t rs2);
		logic [2:0] f3;
		logic [6:0] f7;
		f7 = (op == ALU_SUB) ? 7'b0100000 : 7'b0000000;
		case (op)
			ALU_XOR: f3 = 3'b100;
			ALU_OR:  f3 = 3'b110;
			ALU_AND: f3 = 3'b111;
			default: f3 = 3'b000;
		endcase
		return {f7, rs2, rs1, f3, rd, OP};
	endfunction

	function automatic logic [31:0] enc_addi(input reg_addr_t rd, input reg_addr_t rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, OP_IMM};
	endfunction

	function automatic logic [31:0] enc_lw(input reg_addr_t rd, input reg_addr_t rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b010, rd, LOAD};
	endfunction

	function automatic logic [31:0] enc_sw(input reg_addr_t rs2, input reg_addr_t rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
	endfunction

	// byte offset from the branch itself
	function automatic logic [31:0] enc_branch(input logic ne, input reg_addr_t rs1,
		input reg_addr_t rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], BRANCH};
	endfunction

	// runs to the last word, lists writes to nonzero registers, returns the ebreak count
	function automatic int run_model(input logic [31:0] prog [$],
		output reg_addr_t rds [$], output data_t vals [$]);
		data_t x [32];
		data_t dmem [int];
		logic [31:0] in;
		data_t a, b, res;
		int pc, next_pc, halts, imm_i, imm_s, imm_b, word;
		logic wr;
		rds = {};
		vals = {};
		halts = 0;
		pc = 0;
		foreach (x[i]) begin
			x[i] = '0;
		end
		while (pc >= 0 && pc < prog.size()) begin
			in = prog[pc];
			a = x[in[19:15]];
			b = x[in[24:20]];
			imm_i = int'($signed(in[31:20]));
			imm_s = int'($signed({in[31:25], in[11:7]}));
			imm_b = int'($signed({in[31], in[7], in[30:25], in[11:8], 1'b0}));
			res = '0;
			wr = 1'b0;
			next_pc = pc + 1;
			case (in[6:0])
				OP: begin
					wr = 1'b1;
					case (in[14:12])
						3'b000:  res = in[30] ? a - b : a + b;
						3'b100:  res = a ^ b;
						3'b110:  res = a | b;
						default: res = a & b;
					endcase
				end
				OP_IMM: begin
					wr = 1'b1;
					res = a + data_t'(imm_i);
				end
				LOAD: begin
					wr = 1'b1;
					word = int'((a + data_t'(imm_i)) >> 2);
					res = dmem.exists(word) ? dmem[word] : '0;
				end
				STORE: dmem[int'((a + data_t'(imm_s)) >> 2)] = b;
				BRANCH: begin
					if ((a == b) != in[12]) begin
						next_pc = pc + imm_b / 4;
					end
				end
				SYSTEM: begin
					halts++;
					// only the last ebreak ends the program
					if (pc == prog.size() - 1) begin
						next_pc = -1;
					end
				end
				default: res = '0;
			endcase
			if (wr && in[11:7] != 5'd0) begin
				x[in[11:7]] = res;
				rds.push_back(in[11:7]);
				vals.push_back(res);
			end
			pc = next_pc;
		end
		return halts;
	endfunction

endpackage

`default_nettype wire

/* dv/proc_tb.sv */
// pipelined core testbench
`timescale 1ns/1ps
`default_nettype none

module proc_tb;
	import rv_pkg::*;
	import rv_model::*;

	localparam int NUM_TESTS = 5;
	localparam int RESET_CYCLES = 10;
	localparam int HALT_DWELL = 6;

	logic clk;
	logic rst_n;
	logic imem_we;
	logic [IMEM_AW-1:0] imem_addr;
	logic [31:0] imem_wdata;
	logic debug_resume;
	logic halted;
	logic retire_valid;
	reg_addr_t retire_rd;
	data_t retire_data;

	// all programs back to back, sliced per test
	logic [31:0] prog_words [$];
	int prog_start [NUM_TESTS];
	int prog_len [NUM_TESTS];
	string test_names [NUM_TESTS];
	int num_built;

	// expected retirements, head copied into plain variables for the checks
	reg_addr_t exp_rd_q [$];
	data_t exp_val_q [$];
	logic exp_valid;
	reg_addr_t exp_rd;
	data_t exp_data;
	logic pop_pending;

	string test_name;
	int errors;
	int failed_tests;
	int cycles;
	int cycle_limit;

	proc dut0 (.*);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout: run exceeded %0d cycles in test %s", cycle_limit, test_name);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// an entry leaves the list the cycle after its retirement was checked
	always @(negedge clk) begin
		if (pop_pending && exp_rd_q.size() > 0) begin
			void'(exp_rd_q.pop_front());
			void'(exp_val_q.pop_front());
		end
		pop_pending = retire_valid;
		exp_valid = (exp_rd_q.size() > 0);
		if (exp_valid) begin
			exp_rd = exp_rd_q[0];
			exp_data = exp_val_q[0];
		end else begin
			exp_rd = '0;
			exp_data = '0;
		end
	end

	retire_expected: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid |-> exp_valid)
	else begin
		$display("%s: x%0d retired with nothing left to retire", test_name, $sampled(retire_rd));
		errors++;
	end

	retire_value: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid && exp_valid |-> retire_rd == exp_rd && retire_data == exp_data)
	else begin
		$display("Error %s: expected x%0d=%08h, actual x%0d=%08h", test_name,
			$sampled(exp_rd), $sampled(exp_data), $sampled(retire_rd), $sampled(retire_data));
		errors++;
	end

	halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		halted |-> !retire_valid)
	else begin
		$display("%s: an instruction retired while the core was halted", test_name);
		errors++;
	end

	// ebreak in if/id on a live path halts four edges later
	halt_timing: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(dut0.if_instr == EBREAK_INSTR) && !dut0.flush_front |-> ##4 $rose(halted))
	else begin
		$display("%s: halted did not rise four cycles after EBREAK reached decode", test_name);
		errors++;
	end

	function automatic logic [11:0] rand_imm();
		return 12'($urandom);
	endfunction

	function automatic void add_program(input string name, input logic [31:0] words [$]);
		prog_start[num_built] = prog_words.size();
		prog_len[num_built] = words.size();
		test_names[num_built] = name;
		foreach (words[i]) begin
			prog_words.push_back(words[i]);
		end
		num_built++;
	endfunction

	function automatic void build_programs();
		logic [31:0] p [$];
		reg_addr_t rd, last;
		int kind;
		// dependent chain, then random ops reading the previous result
		p = {};
		p.push_back(enc_addi(1, 0, rand_imm()));
		for (int r = 2; r < 8; r++) begin
			p.push_back(enc_addi(reg_addr_t'(r), reg_addr_t'(r - 1), rand_imm()));
		end
		p.push_back(enc_op(ALU_ADD, 1, 7, 6));
		p.push_back(enc_op(ALU_SUB, 2, 6, 1));
		last = 2;
		for (int i = 0; i < 10; i++) begin
			rd = reg_addr_t'(1 + $urandom % 7);
			kind = $urandom % 6;
			if (kind == 5) begin
				p.push_back(enc_addi(rd, last, rand_imm()));
			end else begin
				p.push_back(enc_op(alu_op_t'(kind), rd, last, reg_addr_t'(1 + $urandom % 7)));
			end
			last = rd;
		end
		p.push_back(EBREAK_INSTR);
		add_program("alu_chain", p);

		p = '{enc_addi(1, 0, 12'h040), enc_addi(2, 0, rand_imm()), enc_sw(2, 1, 12'h000),
			enc_addi(3, 0, rand_imm()), enc_sw(3, 1, 12'h004), enc_lw(4, 1, 12'h000),
			enc_lw(5, 1, 12'h004), enc_op(ALU_ADD, 6, 5, 4), enc_lw(7, 1, 12'h004),
			enc_sw(7, 1, 12'h008), enc_lw(8, 1, 12'h008), enc_op(ALU_ADD, 9, 8, 1),
			EBREAK_INSTR};
		add_program("load_store", p);

		// skipped slots write x4, x8 and x11
		p = '{enc_addi(1, 0, 12'd5), enc_addi(2, 0, 12'd5), enc_addi(3, 0, 12'd7),
			enc_branch(1'b0, 1, 2, 13'd12), enc_addi(4, 0, 12'd1), enc_addi(4, 0, 12'd2),
			enc_addi(5, 0, 12'd3), enc_branch(1'b1, 1, 2, 13'd12), enc_addi(6, 0, 12'd4),
			enc_addi(7, 0, 12'd5), enc_branch(1'b1, 1, 3, 13'd12), enc_addi(8, 0, 12'd6),
			enc_addi(8, 0, 12'd7), enc_branch(1'b0, 1, 3, 13'd8), enc_addi(10, 1, 12'd2),
			enc_branch(1'b0, 10, 3, 13'd8), enc_addi(11, 0, 12'd9), EBREAK_INSTR};
		add_program("branches", p);

		p = '{enc_addi(1, 0, rand_imm()), enc_op(ALU_ADD, 0, 1, 1), enc_op(ALU_ADD, 2, 0, 1),
			enc_addi(0, 1, rand_imm()), enc_op(ALU_OR, 3, 0, 0), enc_op(ALU_SUB, 4, 0, 1),
			EBREAK_INSTR};
		add_program("x0_writes", p);

		p = '{enc_addi(1, 0, rand_imm()), enc_addi(2, 1, rand_imm()), enc_op(ALU_ADD, 3, 1, 2),
			EBREAK_INSTR, enc_addi(4, 3, rand_imm()), enc_op(ALU_SUB, 5, 4, 1),
			EBREAK_INSTR};
		add_program("halt_resume", p);
	endfunction

	task automatic run_test(input int t);
		logic [31:0] words [$];
		reg_addr_t rds [$];
		data_t vals [$];
		int halts;
		int errs_before;
		int n_exp;
		int reset_len;
		for (int i = 0; i < prog_len[t]; i++) begin
			words.push_back(prog_words[prog_start[t] + i]);
		end
		halts = run_model(words, rds, vals);
		n_exp = rds.size();
		test_name = test_names[t];
		errs_before = errors;
		// reset lasts ten cycles, longer if the program needs more to load
		reset_len = (words.size() > RESET_CYCLES) ? words.size() : RESET_CYCLES;
		@(negedge clk);
		rst_n = 1'b0;
		exp_rd_q = rds;
		exp_val_q = vals;
		for (int i = 0; i < reset_len; i++) begin
			imem_we = (i < words.size());
			imem_addr = IMEM_AW'(i);
			imem_wdata = (i < words.size()) ? words[i] : '0;
			@(negedge clk);
		end
		imem_we = 1'b0;
		rst_n = 1'b1;
		@(negedge clk);
		assert (!halted && !retire_valid) else begin
			$display("%s: halted or retire_valid high right after reset", test_name);
			errors++;
		end
		for (int h = 1; h <= halts; h++) begin
			while (!halted) begin
				@(negedge clk);
			end
			if (h < halts) begin
				repeat (HALT_DWELL) @(negedge clk);
				debug_resume = 1'b1;
				@(negedge clk);
				debug_resume = 1'b0;
				while (halted) begin
					@(negedge clk);
				end
			end
		end
		assert (exp_rd_q.size() == 0) else begin
			$display("%s: %0d expected retirements never appeared", test_name, exp_rd_q.size());
			errors++;
		end
		if (errors != errs_before) begin
			failed_tests++;
		end
		$display("%-12s %s, %0d of %0d retirements seen", test_name,
			(errors == errs_before) ? "ok" : "failed", n_exp - exp_rd_q.size(), n_exp);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		debug_resume = 1'b0;
		pop_pending = 1'b0;
		exp_valid = 1'b0;
		exp_rd = '0;
		exp_data = '0;
		errors = 0;
		failed_tests = 0;
		cycles = 0;
		num_built = 0;
		test_name = "setup";
		void'($urandom(32'hf2e1_5e07));
		build_programs();
		cycle_limit = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			cycle_limit += 6 * prog_len[t] + 40;
		end
		for (int t = 0; t < NUM_TESTS; t++) begin
			run_test(t);
		end
		$display("tests: %0d, failed: %0d, errors: %0d", NUM_TESTS, failed_tests, errors);
		if (errors == 0 && failed_tests == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
logic/rv_pkg.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/memory.sv
logic/hazard_ctrl.sv
logic/debug_halt.sv
logic/proc.sv
dv/rv_model.sv
dv/proc_tb.sv

/* Bender.yml */
package:
  name: rv32i_pipe

sources:
  - files:
      - logic/rv_pkg.sv
      - logic/fetch.sv
      - logic/decode.sv
      - logic/execute.sv
      - logic/memory.sv
      - logic/hazard_ctrl.sv
      - logic/debug_halt.sv
      - logic/proc.sv
  - target: test
    files:
      - dv/rv_model.sv
      - dv/proc_tb.sv
